// File: vlog.f
common/regfile_pkg.sv
common/operand_pkg.sv
register_file/scalar_register_file.sv
register_file/vector_register_file.sv
rtl/operand_bypass.sv
rtl/operand_fetch.sv
dv/operand_fetch_props.sv
dv/operand_fetch_checker.sv
dv/operand_fetch_tb.sv

// File: Makefile
# Verilator build and run of the operand fetch testbench

TOP = operand_fetch_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	-./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	cat $(LOG)
	@if grep -qx "RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: dv/operand_fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock(
	output logic clk);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;		// 20 ns period
	end

endmodule

module operand_fetch_tb;

	import regfile_pkg::*;
	import operand_pkg::*;

	localparam int clock_period = 20;
	localparam int reset_cycles = 16;
	localparam int sweep_cycles = num_entries;		// One read per strand and register
	localparam int random_cycles = 4000;
	localparam int drain_cycles = 4;		// Last operands out
	localparam int total_cycles = reset_cycles + sweep_cycles + random_cycles + drain_cycles;
	localparam longint timeout_ns = longint'(total_cycles) * clock_period + 2000;

	logic clk;
	logic reset;
	read_req_t req;
	writeback_t wb;
	operands_t operands;
	integer seed;
	int check_count;
	int value_errors;
	int valid_errors;
	int total_errors;

	tb_clock u_clock(
		.clk(clk));

	operand_fetch u_dut(
		.clk(clk),
		.reset(reset),
		.req(req),
		.wb(wb),
		.operands(operands));

	operand_fetch_checker u_checker(
		.clk(clk),
		.reset(reset),
		.req(req),
		.wb(wb),
		.operands(operands),
		.check_count(check_count),
		.value_errors(value_errors),
		.valid_errors(valid_errors));

	// Protocol checks on the bypass block
	bind operand_bypass operand_fetch_props u_props(
		.clk(clk),
		.reset(reset),
		.req(req),
		.wb(wb),
		.operands(operands));

	function automatic int unsigned draw_below(input int unsigned range);
		return $unsigned($random(seed)) % range;
	endfunction

	// Mostly registers 0 to 3 so reads hit recent writes
	function automatic reg_num_t draw_reg();
		if (draw_below(8) == 0)
			return reg_num_t'(draw_below(num_regs));
		return reg_num_t'(draw_below(4));
	endfunction

	function automatic lane_mask_t draw_mask();
		case (draw_below(4))
			0: return '1;		// Full vector write
			1: return lane_mask_t'(16'h1 << draw_below(num_lanes));		// Single lane
			default: return lane_mask_t'($random(seed));		// Partial, overlapping
		endcase
	endfunction

	task automatic drive_idle();
		req = '0;
		wb = '0;
	endtask

	task automatic drive_sweep_read(input int index);
		req.valid = 1'b1;
		req.strand = strand_t'(index / num_regs);
		req.scalar_sel1 = reg_num_t'(index);
		req.scalar_sel2 = reg_num_t'(index + 7);		// Different register, same strand
		req.vector_sel1 = reg_num_t'(index);
		req.vector_sel2 = reg_num_t'(index + 13);
		wb = '0;
	endtask

	task automatic drive_random_cycle();
		int kind;
		kind = draw_below(10);
		req.valid = (draw_below(4) != 0);		// Mostly back to back
		req.strand = strand_t'(draw_below(num_strands));
		req.scalar_sel1 = draw_reg();
		req.scalar_sel2 = draw_reg();
		req.vector_sel1 = draw_reg();
		req.vector_sel2 = draw_reg();
		wb = '0;
		for (int lane = 0; lane < num_lanes; lane++)
			wb.value[lane] = $random(seed);		// Junk above lane 0 for scalars
		wb.mask = draw_mask();
		wb.reg_index = {strand_t'(draw_below(num_strands)), draw_reg()};
		if (kind >= 4 && kind < 7)
			wb.enable_scalar = 1'b1;
		else if (kind >= 7)
			wb.enable_vector = 1'b1;		// Never both
	endtask

	// Stimulus on the falling edge
	initial
	begin
		seed = 32'h3031;
		reset = 1'b1;
		drive_idle();
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < sweep_cycles; i++)
		begin
			drive_sweep_read(i);		// Everything should read zero
			@(negedge clk);
		end
		for (int i = 0; i < random_cycles; i++)
		begin
			drive_random_cycle();
			@(negedge clk);
		end
		drive_idle();
		repeat (drain_cycles) @(negedge clk);
		total_errors = value_errors + valid_errors + u_dut.u_bypass.u_props.assert_failures;
		$display("checks %0d, value errors %0d, valid errors %0d, assertion failures %0d",
			check_count, value_errors, valid_errors, u_dut.u_bypass.u_props.assert_failures);
		if (total_errors == 0 && check_count > 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(timeout_ns);
		$display("Watchdog expired after %0d ns, the test sequence did not complete", timeout_ns);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/operand_fetch_checker.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fetch_checker(
	input wire clk,
	input wire reset,
	input wire operand_pkg::read_req_t req,
	input wire operand_pkg::writeback_t wb,
	input wire operand_pkg::operands_t operands,
	output int check_count,
	output int value_errors,
	output int valid_errors);

	import regfile_pkg::*;
	import operand_pkg::*;

	scalar_t model_scalar[num_entries];		// Reference scalar file
	vector_t model_vector[num_entries];		// Reference vector file
	read_req_t pending[$];		// Requests waiting one cycle
	int checks = 0;
	int value_fails = 0;
	int valid_fails = 0;

	assign check_count = checks;
	assign value_errors = value_fails;
	assign valid_errors = valid_fails;

	task automatic compare_scalar(input string what, input scalar_t got, input scalar_t expected);
		if (got !== expected)
		begin
			value_fails++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	// One error per vector, first wrong lane shown
	task automatic compare_vector(input string what, input vector_t got, input vector_t expected);
		for (int lane = 0; lane < num_lanes; lane++)
		begin
			if (got[lane] !== expected[lane])
			begin
				value_fails++;
				$display("ERR %0t: %s lane %0d is %h, expected %h",
					$time, what, lane, got[lane], expected[lane]);
				return;
			end
		end
	endtask

	// Writeback of this cycle counts for this cycle's output
	task automatic apply_writeback();
		if (wb.enable_scalar)
			model_scalar[wb.reg_index] = wb.value[0];		// Lane 0 only
		if (wb.enable_vector)
		begin
			for (int lane = 0; lane < num_lanes; lane++)
			begin
				if (wb.mask[lane])
					model_vector[wb.reg_index][lane] = wb.value[lane];
			end
		end
	endtask

	task automatic check_operands(input read_req_t head);
		checks++;
		if (operands.valid !== 1'b1)
		begin
			valid_fails++;
			$display("ERR %0t: operands valid missing one cycle after request", $time);
			return;
		end
		compare_scalar($sformatf("scalar1 strand %0d reg %0d", head.strand, head.scalar_sel1),
			operands.scalar1, model_scalar[{head.strand, head.scalar_sel1}]);
		compare_scalar($sformatf("scalar2 strand %0d reg %0d", head.strand, head.scalar_sel2),
			operands.scalar2, model_scalar[{head.strand, head.scalar_sel2}]);
		compare_vector($sformatf("vector1 strand %0d reg %0d", head.strand, head.vector_sel1),
			operands.vector1, model_vector[{head.strand, head.vector_sel1}]);
		compare_vector($sformatf("vector2 strand %0d reg %0d", head.strand, head.vector_sel2),
			operands.vector2, model_vector[{head.strand, head.vector_sel2}]);
	endtask

	// Values seen here are the ones from before the edge
	always @(posedge clk)
	begin
		read_req_t head;
		if (reset)
		begin
			for (int i = 0; i < num_entries; i++)
			begin
				model_scalar[i] = '0;		// Reset clears both files
				model_vector[i] = '0;
			end
			pending.delete();
		end
		else
		begin
			apply_writeback();
			if (pending.size() > 0)
			begin
				head = pending.pop_front();
				check_operands(head);
			end
			else if (operands.valid !== 1'b0)
			begin
				valid_fails++;
				$display("ERR %0t: operands valid without a request", $time);
			end
			if (req.valid)
				pending.push_back(req);
		end
	end

endmodule

`default_nettype wire

// File: dv/operand_fetch_props.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fetch_props(
	input wire clk,
	input wire reset,
	input wire operand_pkg::read_req_t req,
	input wire operand_pkg::writeback_t wb,
	input wire operand_pkg::operands_t operands);

	int assert_failures = 0;		// Read by the testbench top

	// One register file written per cycle
	wb_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(wb.enable_scalar && wb.enable_vector))
		else
		begin
			assert_failures++;
			$error("Scalar and vector writeback enabled in the same cycle");
		end

	valid_follows_req: assert property (@(posedge clk) disable iff (reset)
		req.valid |=> operands.valid)
		else
		begin
			assert_failures++;
			$error("Operands valid did not follow a request after one cycle");
		end

	// No spurious valids
	valid_needs_req: assert property (@(posedge clk) disable iff (reset)
		operands.valid |-> $past(req.valid))
		else
		begin
			assert_failures++;
			$error("Operands valid without a request one cycle earlier");
		end

	quiet_in_reset: assert property (@(posedge clk) reset |-> !operands.valid)
		else
		begin
			assert_failures++;
			$error("Operands valid high during reset");
		end

endmodule

`default_nettype wire

// File: rtl/operand_fetch.sv
`timescale 1ns/1ns
`default_nettype none

// Operand path top. Both register files see the same request and
// writeback; the bypass block merges in-flight results over their data.
module operand_fetch(
	input wire clk,
	input wire reset,
	input wire operand_pkg::read_req_t req,
	input wire operand_pkg::writeback_t wb,
	output wire operand_pkg::operands_t operands);

	import regfile_pkg::*;

	scalar_t scalar_rd1;		// Scalar file read data
	scalar_t scalar_rd2;
	vector_t vector_rd1;		// Vector file read data
	vector_t vector_rd2;

	scalar_register_file u_scalar_rf(
		.clk(clk),
		.reset(reset),
		.req(req),
		.wb(wb),		// Scalar writes only
		.scalar_rd1(scalar_rd1),
		.scalar_rd2(scalar_rd2));

	vector_register_file u_vector_rf(
		.clk(clk),
		.reset(reset),
		.req(req),
		.wb(wb),		// Masked vector writes only
		.vector_rd1(vector_rd1),
		.vector_rd2(vector_rd2));

	operand_bypass u_bypass(
		.clk(clk),
		.reset(reset),
		.req(req),		// Staged alongside the read
		.wb(wb),		// Current and delayed sources
		.scalar_rd1(scalar_rd1),
		.scalar_rd2(scalar_rd2),
		.vector_rd1(vector_rd1),
		.vector_rd2(vector_rd2),
		.operands(operands));

endmodule

`default_nettype wire

// File: rtl/operand_bypass.sv
`timescale 1ns/1ns
`default_nettype none

// Sits behind both register files. Their read data can be stale by up
// to two writebacks: the one applied at the read edge itself, and the
// one presented while the operands are being returned.
module operand_bypass(
	input wire clk,
	input wire reset,
	input wire operand_pkg::read_req_t req,
	input wire operand_pkg::writeback_t wb,
	input wire regfile_pkg::scalar_t scalar_rd1,
	input wire regfile_pkg::scalar_t scalar_rd2,
	input wire regfile_pkg::vector_t vector_rd1,
	input wire regfile_pkg::vector_t vector_rd2,
	output operand_pkg::operands_t operands);

	import regfile_pkg::*;
	import operand_pkg::*;

	read_req_t req_q;		// Request, aligned with register file data
	writeback_t wb_q;		// Delayed writeback, missed by the read
	reg_index_t scalar1_index;
	reg_index_t scalar2_index;
	reg_index_t vector1_index;
	reg_index_t vector2_index;

	// Newest value of one scalar, whole word
	function automatic scalar_t merge_scalar(
		input writeback_t newest,
		input writeback_t older,
		input reg_index_t index,
		input scalar_t rf_value);
		scalar_t result;
		result = rf_value;		// Register file as the fallback
		if (older.enable_scalar && older.reg_index == index)
			result = older.value[0];		// Delayed writeback
		if (newest.enable_scalar && newest.reg_index == index)
			result = newest.value[0];		// Current writeback wins
		return result;
	endfunction

	// Newest value of one vector, resolved per lane
	function automatic vector_t merge_vector(
		input writeback_t newest,
		input writeback_t older,
		input reg_index_t index,
		input vector_t rf_value);
		vector_t result;
		logic newest_hit;
		logic older_hit;
		newest_hit = newest.enable_vector && newest.reg_index == index;
		older_hit = older.enable_vector && older.reg_index == index;
		for (int lane = 0; lane < num_lanes; lane++)
		begin
			if (newest_hit && newest.mask[lane])
				result[lane] = newest.value[lane];		// Current lane write
			else if (older_hit && older.mask[lane])
				result[lane] = older.value[lane];		// Older lane write
			else
				result[lane] = rf_value[lane];		// Untouched lane
		end
		return result;
	endfunction

	// Request and writeback staged with the register file read
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			req_q <= '0;		// No operands pending
			wb_q <= '0;		// Delayed enables low
		end
		else
		begin
			req_q <= req;
			wb_q <= wb;		// Applied at this edge, after the read
		end
	end

	// Flat indices of the operands in flight
	assign scalar1_index = {req_q.strand, req_q.scalar_sel1};
	assign scalar2_index = {req_q.strand, req_q.scalar_sel2};
	assign vector1_index = {req_q.strand, req_q.vector_sel1};
	assign vector2_index = {req_q.strand, req_q.vector_sel2};

	// Combinational from wb so a same-cycle result is seen
	always_comb
	begin
		operands.valid = req_q.valid;		// Latency of one
		operands.scalar1 = merge_scalar(wb, wb_q, scalar1_index, scalar_rd1);
		operands.scalar2 = merge_scalar(wb, wb_q, scalar2_index, scalar_rd2);
		operands.vector1 = merge_vector(wb, wb_q, vector1_index, vector_rd1);
		operands.vector2 = merge_vector(wb, wb_q, vector2_index, vector_rd2);
	end

endmodule

`default_nettype wire

// File: register_file/vector_register_file.sv
`timescale 1ns/1ns
`default_nettype none

module vector_register_file(
	input wire clk,
	input wire reset,
	input wire operand_pkg::read_req_t req,
	input wire operand_pkg::writeback_t wb,
	output regfile_pkg::vector_t vector_rd1,
	output regfile_pkg::vector_t vector_rd2);

	import regfile_pkg::*;

	vector_t regs[num_entries];		// 128 vectors of 16 lanes
	reg_index_t rd_index1;
	reg_index_t rd_index2;

	assign rd_index1 = {req.strand, req.vector_sel1};		// Same strand for both reads
	assign rd_index2 = {req.strand, req.vector_sel2};

	// Write port, lane by lane under the mask
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_entries; i++)
				regs[i] <= '0;		// Clear all strands
		end
		else if (wb.enable_vector)
		begin
			for (int lane = 0; lane < num_lanes; lane++)
			begin
				if (wb.mask[lane])
					regs[wb.reg_index][lane] <= wb.value[lane];		// Disabled lanes hold
			end
		end
	end

	// Read ports, registered, pre-write contents
	always_ff @(posedge clk)
	begin
		if (req.valid)
		begin
			vector_rd1 <= regs[rd_index1];
			vector_rd2 <= regs[rd_index2];
		end
	end

endmodule

`default_nettype wire

// File: register_file/scalar_register_file.sv
`timescale 1ns/1ns
`default_nettype none

module scalar_register_file(
	input wire clk,
	input wire reset,
	input wire operand_pkg::read_req_t req,
	input wire operand_pkg::writeback_t wb,
	output regfile_pkg::scalar_t scalar_rd1,
	output regfile_pkg::scalar_t scalar_rd2);

	import regfile_pkg::*;

	scalar_t regs[num_entries];		// All strands, strand in upper index bits
	reg_index_t rd_index1;
	reg_index_t rd_index2;

	assign rd_index1 = {req.strand, req.scalar_sel1};		// Flat storage address
	assign rd_index2 = {req.strand, req.scalar_sel2};

	// Write port, lane 0 of the writeback value only
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < num_entries; i++)
				regs[i] <= '0;		// Every register reads zero after reset
		end
		else if (wb.enable_scalar)
			regs[wb.reg_index] <= wb.value[0];
	end

	// Read ports, registered
	// Old contents are sampled when a write hits the same edge,
	// the bypass block covers that case
	always_ff @(posedge clk)
	begin
		if (req.valid)
		begin
			scalar_rd1 <= regs[rd_index1];
			scalar_rd2 <= regs[rd_index2];
		end
	end

endmodule

`default_nettype wire

// File: common/operand_pkg.sv
`default_nettype none

// Operand path payloads
package operand_pkg;

	import regfile_pkg::*;

	// One read of two scalars and two vectors from a single strand
	typedef struct packed {
		logic valid;		// One-cycle strobe
		strand_t strand;		// Strand being read
		reg_num_t scalar_sel1;		// First scalar source
		reg_num_t scalar_sel2;		// Second scalar source
		reg_num_t vector_sel1;		// First vector source
		reg_num_t vector_sel2;		// Second vector source
	} read_req_t;

	// Result headed for one of the register files
	typedef struct packed {
		logic enable_scalar;		// Scalar write strobe
		logic enable_vector;		// Vector write strobe, never with scalar
		reg_index_t reg_index;		// Strand and register together
		vector_t value;		// Scalar writes use lane 0
		lane_mask_t mask;		// Lane enables, vector writes only
	} writeback_t;

	// Resolved operands, newest values merged in
	typedef struct packed {
		logic valid;		// One cycle after the request
		scalar_t scalar1;
		scalar_t scalar2;
		vector_t vector1;
		vector_t vector2;
	} operands_t;

endpackage

`default_nettype wire

// File: common/regfile_pkg.sv
`default_nettype none

// Register file geometry shared by the scalar and vector files
package regfile_pkg;

	localparam int num_strands = 4;		// Hardware strands
	localparam int num_regs = 32;		// Registers per strand, per file
	localparam int num_lanes = 16;		// 32-bit lanes per vector
	localparam int lane_width = 32;		// Bits per lane and per scalar

	// Storage depth of each file, all strands together
	localparam int num_entries = num_strands * num_regs;

	typedef logic [$clog2(num_strands)-1:0] strand_t;		// Strand number
	typedef logic [$clog2(num_regs)-1:0] reg_num_t;		// Register within a strand

	// Strand in the upper bits, register below
	typedef logic [$clog2(num_entries)-1:0] reg_index_t;

	typedef logic [lane_width-1:0] scalar_t;		// One word, also one lane

	// Lane i sits in bits 32i up to 32i+31
	typedef scalar_t [num_lanes-1:0] vector_t;

	typedef logic [num_lanes-1:0] lane_mask_t;		// Bit i enables lane i

endpackage

`default_nettype wire
